// ==== src/xcom_pkg.sv ====
package xcom_pkg;

  ////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////

  // board address, also used as board id
  typedef logic [3:0]  xcom_addr_t;
  // command data word
  typedef logic [31:0] xcom_data_t;
  // wrapping count of accepted commands
  typedef logic [3:0]  xcom_cnt_t;
  // payload length code carried in the frame header
  typedef logic [1:0]  xcom_len_t;

  // opcode bit that marks a network command
  localparam int XCOM_NET_BIT = 4;

  // length codes
  localparam xcom_len_t XCOM_LEN_8  = 2'd0;
  localparam xcom_len_t XCOM_LEN_16 = 2'd1;
  localparam xcom_len_t XCOM_LEN_32 = 2'd2;

  // destination that every board accepts
  localparam xcom_addr_t XCOM_BCAST_ADDR = 4'hF;

  ////////////////////////////////////////////////////////////
  // opcodes and bundles
  ////////////////////////////////////////////////////////////

  // zero is a no-op, acked locally
  typedef enum logic [4:0] {
    LOC_NOP      = 5'h00,
    LOC_SET_ID   = 5'h01,
    LOC_SET_FLAG = 5'h02,
    LOC_SYNC     = 5'h03,
    NET_SEND_8   = 5'h11,
    NET_SEND_16  = 5'h12,
    NET_SEND_32  = 5'h13
  } xcom_op_e;

  // 41 bits
  typedef struct packed {
    xcom_op_e   op;
    xcom_addr_t addr;
    xcom_data_t data;
  } xcom_cmd_t;

  // 42 bits, payload right-aligned and zero-filled
  typedef struct packed {
    xcom_addr_t src;
    xcom_addr_t dst;
    xcom_len_t  len;
    xcom_data_t payload;
  } xcom_frame_t;

endpackage

// ==== src/xcom_cmd.sv ====
`timescale 1ns/100ps

module xcom_cmd
  import xcom_pkg::*;
(
  // sequencer command
  input  logic       i_tproc_en,
  input  xcom_op_e   i_tproc_op,
  input  xcom_addr_t i_tproc_addr,
  input  xcom_data_t i_tproc_data,
  // host command, opcode in [5:1], strobe in [0]
  input  logic [5:0] i_ps_ctrl,
  input  xcom_addr_t i_ps_addr,
  input  xcom_data_t i_ps_data,
  // merged command
  output logic       o_cmd_vld,
  output xcom_cmd_t  o_cmd
);

  // unpacked host control word
  logic       ps_vld;
  logic [4:0] ps_op;

  assign ps_vld = i_ps_ctrl[0];
  assign ps_op  = i_ps_ctrl[5:1];

  ////////////////////////////////////////////////////////////
  // source merge
  ////////////////////////////////////////////////////////////

  // an idle source drives all zeros, so OR selects the active one
  // both sources strobing together gives a garbled command
  assign o_cmd_vld = ps_vld | i_tproc_en;

  // opcode is merged as a plain vector, then typed again
  assign o_cmd.op   = xcom_op_e'(ps_op | i_tproc_op);
  assign o_cmd.addr = i_ps_addr | i_tproc_addr;
  assign o_cmd.data = i_ps_data | i_tproc_data;

endmodule

// ==== src/req_ack_cmd.sv ====
`timescale 1ns/100ps

module req_ack_cmd
  import xcom_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  // merged command strobe
  input  logic      i_cmd_vld,
  input  xcom_cmd_t i_cmd,
  // acks from executor and transmitter
  input  logic      i_ack_loc,
  input  logic      i_ack_net,
  // requests and held command
  output logic      o_req_loc,
  output logic      o_req_net,
  output xcom_cmd_t o_cmd,
  output xcom_cnt_t o_cmd_cntr
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_e;

  state_e    state;
  xcom_cmd_t cmd_q;
  xcom_cnt_t cntr;

  logic accept;
  logic is_net;
  logic ack_hit;

  ////////////////////////////////////////////////////////////
  // accept and route
  ////////////////////////////////////////////////////////////

  // strobes while waiting are dropped, also in the ack cycle
  assign accept = i_cmd_vld & (state == ST_IDLE);

  // route by the network bit of the held opcode
  assign is_net = cmd_q.op[XCOM_NET_BIT];

  assign o_req_loc = (state == ST_WAIT) & ~is_net;
  assign o_req_net = (state == ST_WAIT) &  is_net;

  // only the ack that matches the raised request counts
  assign ack_hit = (o_req_loc & i_ack_loc) | (o_req_net & i_ack_net);

  // request state and counter
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
      cntr  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_WAIT;
            cntr  <= cntr + 1'b1;
          end
        end
        ST_WAIT: begin
          // request drops in the cycle after the ack
          if (ack_hit) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // command hold register
  always_ff @(posedge i_clk) begin
    if (accept) begin
      cmd_q <= i_cmd;
    end
  end

  assign o_cmd      = cmd_q;
  assign o_cmd_cntr = cntr;

endmodule

// ==== src/xcom_loc_exec.sv ====
`timescale 1ns/100ps

module xcom_loc_exec
  import xcom_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  // local request and its command
  input  logic       i_req,
  input  xcom_cmd_t  i_cmd,
  // ack back to the request stage
  output logic       o_ack,
  // local state
  output xcom_addr_t o_board_id,
  output logic       o_flag,
  output logic       o_sync
);

  // request still high during our own ack cycle, so mask it
  logic start;

  assign start = i_req & ~o_ack;

  ////////////////////////////////////////////////////////////
  // command execution
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ack      <= 1'b0;
      o_sync     <= 1'b0;
      o_board_id <= '0;
      o_flag     <= 1'b0;
    end else begin
      // ack and effect land on the same edge
      o_ack  <= start;
      // single-cycle sync pulse
      o_sync <= start & (i_cmd.op == LOC_SYNC);
      if (start) begin
        case (i_cmd.op)
          // id from the low nibble of data
          LOC_SET_ID:   o_board_id <= i_cmd.data[3:0];
          // flag from data bit 0
          LOC_SET_FLAG: o_flag     <= i_cmd.data[0];
          // nop and unknown local codes only ack
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== src/xcom_tx.sv ====
`timescale 1ns/100ps

module xcom_tx
  import xcom_pkg::*;
#(
  parameter int P_BIT_CYCLES = 4
) (
  input  logic       i_clk,
  input  logic       i_rst_n,
  // network request and its command
  input  logic       i_req,
  input  xcom_cmd_t  i_cmd,
  // source id placed in the header
  input  xcom_addr_t i_board_id,
  output logic       o_ack,
  // serial line, idles high
  output logic       o_tx_line
);

  localparam int P_CW = $clog2(P_BIT_CYCLES);
  localparam logic [P_CW-1:0] P_LAST = P_CW'(P_BIT_CYCLES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_STOP
  } state_e;

  state_e          state;
  // start, src, dst, len, up to 32 payload bits, msb goes first
  logic [42:0]     sreg;
  logic [P_CW-1:0] per_cnt;
  logic [5:0]      bit_cnt;

  logic       per_end;
  xcom_len_t  len_code;
  xcom_data_t pay_al;
  logic [5:0] last_idx;

  assign per_end = (per_cnt == P_LAST);

  ////////////////////////////////////////////////////////////
  // frame build
  ////////////////////////////////////////////////////////////

  // length from opcode, unknown network codes send 8 bits
  // payload moved to the top so it shifts out msb first
  // last_idx is the shift count minus one (11 framing bits + payload)
  always_comb begin
    case (i_cmd.op)
      NET_SEND_16: begin
        len_code = XCOM_LEN_16;
        pay_al   = {i_cmd.data[15:0], 16'h0};
        last_idx = 6'd26;
      end
      NET_SEND_32: begin
        len_code = XCOM_LEN_32;
        pay_al   = i_cmd.data;
        last_idx = 6'd42;
      end
      default: begin
        len_code = XCOM_LEN_8;
        pay_al   = {i_cmd.data[7:0], 24'h0};
        last_idx = 6'd18;
      end
    endcase
  end

  // control path
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state   <= ST_IDLE;
      per_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          per_cnt <= '0;
          if (i_req) begin
            state   <= ST_SHIFT;
            bit_cnt <= last_idx;
          end
        end
        ST_SHIFT: begin
          per_cnt <= per_end ? '0 : per_cnt + 1'b1;
          if (per_end) begin
            if (bit_cnt == '0) begin
              state <= ST_STOP;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        ST_STOP: begin
          per_cnt <= per_end ? '0 : per_cnt + 1'b1;
          if (per_end) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // shift register, loaded on the request
  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_req) begin
      sreg <= {1'b0, i_board_id, i_cmd.addr, len_code, pay_al};
    end else if (state == ST_SHIFT && per_end) begin
      sreg <= {sreg[41:0], 1'b0};
    end
  end

  // stop bit and idle are both high
  assign o_tx_line = (state == ST_SHIFT) ? sreg[42] : 1'b1;

  // ack in the last cycle of the stop bit
  assign o_ack = (state == ST_STOP) & per_end;

endmodule

// ==== src/xcom_rx.sv ====
`timescale 1ns/100ps

module xcom_rx
  import xcom_pkg::*;
#(
  parameter int P_BIT_CYCLES = 4
) (
  input  logic        i_clk,
  input  logic        i_rst_n,
  // serial line, already in this clock domain
  input  logic        i_rx_line,
  // filter id
  input  xcom_addr_t  i_board_id,
  output logic        o_rx_vld,
  output xcom_frame_t o_rx_frame
);

  localparam int P_CW = $clog2(P_BIT_CYCLES);
  localparam logic [P_CW-1:0] P_HALF = P_CW'(P_BIT_CYCLES / 2);
  localparam logic [P_CW-1:0] P_LAST = P_CW'(P_BIT_CYCLES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } state_e;

  state_e          state;
  logic            line_d;
  logic [P_CW-1:0] per_cnt;
  logic [5:0]      bit_cnt;
  // src, dst, len
  logic [9:0]      hdr_sr;
  xcom_data_t      pay_sr;

  logic       sample;
  logic       last_bit;
  logic       dst_ok;
  logic [5:0] last_idx;

  // mid-period sample point
  assign sample = (per_cnt == P_HALF);

  // last data index is 9 + payload bits
  // never matches while the header is still coming in
  always_comb begin
    case (hdr_sr[1:0])
      XCOM_LEN_8:  last_idx = 6'd17;
      XCOM_LEN_16: last_idx = 6'd25;
      default:     last_idx = 6'd41;
    endcase
  end

  assign last_bit = (bit_cnt == last_idx);

  // own id or broadcast
  assign dst_ok = (hdr_sr[5:2] == i_board_id) | (hdr_sr[5:2] == XCOM_BCAST_ADDR);

  ////////////////////////////////////////////////////////////
  // receive FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state    <= ST_IDLE;
      line_d   <= 1'b1;
      per_cnt  <= '0;
      bit_cnt  <= '0;
      o_rx_vld <= 1'b0;
    end else begin
      line_d   <= i_rx_line;
      o_rx_vld <= 1'b0;
      if (state != ST_IDLE) begin
        per_cnt <= (per_cnt == P_LAST) ? '0 : per_cnt + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          // falling edge, first low cycle was period index 0
          if (line_d && !i_rx_line) begin
            state   <= ST_START;
            per_cnt <= P_CW'(1);
          end
        end
        ST_START: begin
          // glitch back to high, not a start bit
          if (sample) begin
            state   <= i_rx_line ? ST_IDLE : ST_DATA;
            bit_cnt <= '0;
          end
        end
        ST_DATA: begin
          if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              state <= ST_STOP;
            end
          end
        end
        ST_STOP: begin
          // a low stop bit drops the frame
          if (sample) begin
            state    <= ST_IDLE;
            o_rx_vld <= i_rx_line & dst_ok;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // header and payload shift, payload cleared while idle
  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE) begin
      pay_sr <= '0;
    end else if (state == ST_DATA && sample) begin
      if (bit_cnt < 6'd10) begin
        hdr_sr <= {hdr_sr[8:0], i_rx_line};
      end else begin
        pay_sr <= {pay_sr[30:0], i_rx_line};
      end
    end
  end

  // frame output, updated with the stop sample
  always_ff @(posedge i_clk) begin
    if (state == ST_STOP && sample) begin
      o_rx_frame.src     <= hdr_sr[9:6];
      o_rx_frame.dst     <= hdr_sr[5:2];
      o_rx_frame.len     <= hdr_sr[1:0];
      o_rx_frame.payload <= pay_sr;
    end
  end

endmodule

// ==== src/xcom_top.sv ====
`timescale 1ns/100ps

module xcom_top
  import xcom_pkg::*;
#(
  parameter int P_BIT_CYCLES = 4
) (
  input  logic        i_clk,
  input  logic        i_rst_n,
  // sequencer command
  input  logic        i_tproc_en,
  input  xcom_op_e    i_tproc_op,
  input  xcom_addr_t  i_tproc_addr,
  input  xcom_data_t  i_tproc_data,
  // host command
  input  logic [5:0]  i_ps_ctrl,
  input  xcom_addr_t  i_ps_addr,
  input  xcom_data_t  i_ps_data,
  // serial input
  input  logic        i_rx_line,
  // status
  output logic        o_req_loc,
  output logic        o_req_net,
  output xcom_cnt_t   o_cmd_cntr,
  output xcom_addr_t  o_board_id,
  output logic        o_flag,
  output logic        o_sync,
  // serial output and received frames
  output logic        o_tx_line,
  output logic        o_rx_vld,
  output xcom_frame_t o_rx_frame
);

  logic      cmd_vld;
  xcom_cmd_t cmd;
  xcom_cmd_t req_cmd;
  logic      ack_loc;
  logic      ack_net;

  ////////////////////////////////////////////////////////////
  // command path
  ////////////////////////////////////////////////////////////

  xcom_cmd u_xcom_cmd (
    .i_tproc_en   (i_tproc_en),
    .i_tproc_op   (i_tproc_op),
    .i_tproc_addr (i_tproc_addr),
    .i_tproc_data (i_tproc_data),
    .i_ps_ctrl    (i_ps_ctrl),
    .i_ps_addr    (i_ps_addr),
    .i_ps_data    (i_ps_data),
    .o_cmd_vld    (cmd_vld),
    .o_cmd        (cmd)
  );

  req_ack_cmd u_req_ack_cmd (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cmd_vld  (cmd_vld),
    .i_cmd      (cmd),
    .i_ack_loc  (ack_loc),
    .i_ack_net  (ack_net),
    .o_req_loc  (o_req_loc),
    .o_req_net  (o_req_net),
    .o_cmd      (req_cmd),
    .o_cmd_cntr (o_cmd_cntr)
  );

  // board id feeds both tx header and rx filter
  xcom_loc_exec u_xcom_loc_exec (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (o_req_loc),
    .i_cmd      (req_cmd),
    .o_ack      (ack_loc),
    .o_board_id (o_board_id),
    .o_flag     (o_flag),
    .o_sync     (o_sync)
  );

  // serial link
  xcom_tx #(
    .P_BIT_CYCLES (P_BIT_CYCLES)
  ) u_xcom_tx (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (o_req_net),
    .i_cmd      (req_cmd),
    .i_board_id (o_board_id),
    .o_ack      (ack_net),
    .o_tx_line  (o_tx_line)
  );

  xcom_rx #(
    .P_BIT_CYCLES (P_BIT_CYCLES)
  ) u_xcom_rx (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rx_line  (i_rx_line),
    .i_board_id (o_board_id),
    .o_rx_vld   (o_rx_vld),
    .o_rx_frame (o_rx_frame)
  );

endmodule

// ==== tb/tb_xcom_top.sv ====
`timescale 1ns/100ps

module tb_xcom_top
  import xcom_pkg::*;
;

  localparam int CLK_PERIOD = 100;
  localparam int P_BIT      = 4;
  // worst case frame is 12 framing bits plus 32 payload bits
  localparam int FRAME_CYCLES = 44 * P_BIT;
  localparam int REQ_LIMIT    = FRAME_CYCLES + 8;
  localparam int N_NET        = 12;
  localparam int N_LOC        = 8;
  // each frame plus its quiet window, local commands, reset and margin
  localparam int WATCHDOG_CYCLES = N_NET * (FRAME_CYCLES + 4 * P_BIT) + N_LOC * 10 + 200;

  // expected frame fields
  typedef struct packed {
    xcom_addr_t src;
    xcom_addr_t dst;
    xcom_len_t  len;
    xcom_data_t payload;
  } exp_frame_t;

  logic        clk;
  logic        rst_n;
  logic        i_tproc_en;
  xcom_op_e    i_tproc_op;
  xcom_addr_t  i_tproc_addr;
  xcom_data_t  i_tproc_data;
  logic [5:0]  i_ps_ctrl;
  xcom_addr_t  i_ps_addr;
  xcom_data_t  i_ps_data;
  logic        rx_line;
  logic        o_req_loc;
  logic        o_req_net;
  xcom_cnt_t   o_cmd_cntr;
  xcom_addr_t  o_board_id;
  logic        o_flag;
  logic        o_sync;
  logic        o_tx_line;
  logic        o_rx_vld;
  xcom_frame_t o_rx_frame;

  // reference model
  xcom_addr_t exp_id;
  logic       exp_flag;
  xcom_cnt_t  exp_cnt;
  int         exp_sync;
  int         sync_cnt;
  exp_frame_t exp_q[$];
  int         errors;
  int         seed = 51540;

  xcom_top #(
    .P_BIT_CYCLES (P_BIT)
  ) u_xcom_top (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_tproc_en   (i_tproc_en),
    .i_tproc_op   (i_tproc_op),
    .i_tproc_addr (i_tproc_addr),
    .i_tproc_data (i_tproc_data),
    .i_ps_ctrl    (i_ps_ctrl),
    .i_ps_addr    (i_ps_addr),
    .i_ps_data    (i_ps_data),
    .i_rx_line    (rx_line),
    .o_req_loc    (o_req_loc),
    .o_req_net    (o_req_net),
    .o_cmd_cntr   (o_cmd_cntr),
    .o_board_id   (o_board_id),
    .o_flag       (o_flag),
    .o_sync       (o_sync),
    .o_tx_line    (o_tx_line),
    .o_rx_vld     (o_rx_vld),
    .o_rx_frame   (o_rx_frame)
  );

  // serial loopback
  assign rx_line = o_tx_line;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // error reporting and model helpers
  ////////////////////////////////////////////////////////////

  task automatic note_error(input string msg);
    errors++;
    $display("FAIL at %0t: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // length code and masked payload per the frame format
  function automatic xcom_len_t len_of(input xcom_op_e op);
    case (op)
      NET_SEND_8:  return 2'd0;
      NET_SEND_16: return 2'd1;
      default:     return 2'd2;
    endcase
  endfunction

  function automatic xcom_data_t mask_payload(input xcom_op_e op, input xcom_data_t d);
    case (op)
      NET_SEND_8:  return {24'h0, d[7:0]};
      NET_SEND_16: return {16'h0, d[15:0]};
      default:     return d;
    endcase
  endfunction

  // update expectations for an accepted command
  task automatic expect_cmd(input xcom_op_e op, input xcom_addr_t addr, input xcom_data_t d);
    exp_frame_t f;
    exp_cnt = exp_cnt + 1'b1;
    case (op)
      LOC_SET_ID:   exp_id = d[3:0];
      LOC_SET_FLAG: exp_flag = d[0];
      LOC_SYNC:     exp_sync++;
      default: ;
    endcase
    // frames only come back when the filter lets them through
    if (op[4] && (addr == exp_id || addr == XCOM_BCAST_ADDR)) begin
      f.src     = exp_id;
      f.dst     = addr;
      f.len     = len_of(op);
      f.payload = mask_payload(op, d);
      exp_q.push_back(f);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic clear_inputs();
    i_tproc_en   = 1'b0;
    i_tproc_op   = LOC_NOP;
    i_tproc_addr = '0;
    i_tproc_data = '0;
    i_ps_ctrl    = '0;
    i_ps_addr    = '0;
    i_ps_data    = '0;
  endtask

  // one-cycle strobe from the chosen source while the idle source stays all zeros
  task automatic issue_cmd(input logic from_host, input xcom_op_e op,
                           input xcom_addr_t addr, input xcom_data_t d);
    @(posedge clk);
    #10;
    if (from_host) begin
      i_ps_ctrl = {op, 1'b1};
      i_ps_addr = addr;
      i_ps_data = d;
    end else begin
      i_tproc_en   = 1'b1;
      i_tproc_op   = op;
      i_tproc_addr = addr;
      i_tproc_data = d;
    end
    @(posedge clk);
    #10;
    clear_inputs();
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((o_req_loc || o_req_net) && n < REQ_LIMIT) begin
      @(posedge clk);
      #10;
      n++;
    end
    req_falls: assert (!o_req_loc && !o_req_net)
      else report_problem("request still high after the bounded wait");
  endtask

  // frames come back before the request falls and a quiet window follows
  task automatic drain_rx_frames();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < FRAME_CYCLES) begin
      @(posedge clk);
      n++;
    end
    frames_seen: assert (exp_q.size() == 0)
      else report_problem("expected loopback frame never arrived");
    exp_q.delete();
    repeat (2 * P_BIT) @(posedge clk);
  endtask

  task automatic check_state();
    id_ok: assert (o_board_id == exp_id)
      else note_error($sformatf("o_board_id %0h, expected %0h", o_board_id, exp_id));
    flag_ok: assert (o_flag == exp_flag)
      else note_error($sformatf("o_flag %0b, expected %0b", o_flag, exp_flag));
    cnt_ok: assert (o_cmd_cntr == exp_cnt)
      else note_error($sformatf("o_cmd_cntr %0d, expected %0d", o_cmd_cntr, exp_cnt));
    sync_ok: assert (sync_cnt == exp_sync)
      else note_error($sformatf("%0d sync pulses, expected %0d", sync_cnt, exp_sync));
  endtask

  task automatic run_cmd(input logic from_host, input xcom_op_e op,
                         input xcom_addr_t addr, input xcom_data_t d);
    issue_cmd(from_host, op, addr, d);
    expect_cmd(op, addr, d);
    // top opcode bit selects the network path
    if (op[4]) begin
      route_net: assert (o_req_net && !o_req_loc)
        else note_error($sformatf("%s did not raise only o_req_net", op.name()));
    end else begin
      route_loc: assert (o_req_loc && !o_req_net)
        else note_error($sformatf("%s did not raise only o_req_loc", op.name()));
    end
    wait_idle();
    check_state();
    if (op[4]) begin
      drain_rx_frames();
    end
  endtask

  // second strobe lands while the first frame is still going out
  task automatic send_while_busy(input xcom_data_t d_first, input xcom_data_t d_drop);
    issue_cmd(1'b0, NET_SEND_32, exp_id, d_first);
    expect_cmd(NET_SEND_32, exp_id, d_first);
    busy_before: assert (o_req_net)
      else note_error("o_req_net low right after a network command");
    issue_cmd(1'b1, NET_SEND_8, exp_id, d_drop);
    busy_after: assert (o_req_net)
      else note_error("o_req_net low while the first frame is in flight");
    wait_idle();
    check_state();
    drain_rx_frames();
  endtask

  ////////////////////////////////////////////////////////////
  // monitors and concurrent checks
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n && o_sync) begin
      sync_cnt++;
    end
  end

  // received frames must match the queue in order
  always @(negedge clk) begin : rx_check
    exp_frame_t e;
    if (rst_n && o_rx_vld) begin
      if (exp_q.size() == 0) begin
        report_problem("frame received although none was expected");
      end else begin
        e = exp_q.pop_front();
        frame_src: assert (o_rx_frame.src == e.src)
          else note_error($sformatf("frame src %0h, expected %0h", o_rx_frame.src, e.src));
        frame_dst: assert (o_rx_frame.dst == e.dst)
          else note_error($sformatf("frame dst %0h, expected %0h", o_rx_frame.dst, e.dst));
        frame_len: assert (o_rx_frame.len == e.len)
          else note_error($sformatf("frame len %0d, expected %0d", o_rx_frame.len, e.len));
        frame_pay: assert (o_rx_frame.payload == e.payload)
          else note_error($sformatf("payload %08h, expected %08h",
                                    o_rx_frame.payload, e.payload));
      end
    end
  end

  req_excl: assert property (@(posedge clk) disable iff (!rst_n) !(o_req_loc && o_req_net))
    else note_error("o_req_loc and o_req_net high together");
  sync_single: assert property (@(posedge clk) disable iff (!rst_n) o_sync |=> !o_sync)
    else note_error("o_sync longer than one cycle");
  sync_local: assert property (@(posedge clk) disable iff (!rst_n) o_sync |-> o_req_loc)
    else note_error("o_sync without a local request");

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    xcom_data_t d;
    xcom_data_t d2;
    xcom_op_e   op;
    int         k;
    clear_inputs();
    rst_n    = 1'b0;
    errors   = 0;
    exp_id   = '0;
    exp_flag = 1'b0;
    exp_cnt  = '0;
    exp_sync = 0;
    sync_cnt = 0;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    rst_vals: assert (!o_req_loc && !o_req_net && !o_sync && !o_rx_vld && o_tx_line &&
                      o_board_id == 4'h0 && !o_flag && o_cmd_cntr == 4'h0)
      else note_error("outputs not at their reset values");

    // local commands from both sources
    d = $random(seed);
    run_cmd(1'b0, LOC_SET_ID, 4'h0, {d[31:4], 4'h3});
    run_cmd(1'b1, LOC_SET_FLAG, 4'h0, 32'h1);
    run_cmd(1'b0, LOC_SET_FLAG, 4'h0, 32'hFFFF_FFFE);
    run_cmd(1'b0, LOC_SYNC, 4'h0, 32'h0);
    run_cmd(1'b1, LOC_SYNC, 4'h0, 32'h0);
    run_cmd(1'b0, LOC_NOP, 4'h0, 32'h0);

    // loopback to own id, all three lengths
    run_cmd(1'b0, NET_SEND_8, exp_id, $random(seed));
    run_cmd(1'b1, NET_SEND_16, exp_id, $random(seed));
    run_cmd(1'b0, NET_SEND_32, exp_id, $random(seed));

    // broadcast gets through but a foreign address does not
    run_cmd(1'b1, NET_SEND_16, XCOM_BCAST_ADDR, $random(seed));
    run_cmd(1'b0, NET_SEND_8, 4'h7, $random(seed));

    // new id from the host and frames that follow it
    run_cmd(1'b1, LOC_SET_ID, 4'h0, 32'h9);
    run_cmd(1'b1, LOC_SET_FLAG, 4'h0, 32'h1);
    run_cmd(1'b1, NET_SEND_32, exp_id, $random(seed));

    d  = $random(seed);
    d2 = $random(seed);
    send_while_busy(d, d2);

    // random lengths from alternating sources so the counter wraps past 16
    for (int i = 0; i < 5; i++) begin
      k = $unsigned($random(seed)) % 3;
      op = (k == 0) ? NET_SEND_8 : (k == 1) ? NET_SEND_16 : NET_SEND_32;
      run_cmd(i[0], op, exp_id, $random(seed));
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== bender.yml ====
package:
  name: xcom

sources:
  - src/xcom_pkg.sv
  - src/xcom_cmd.sv
  - src/req_ack_cmd.sv
  - src/xcom_loc_exec.sv
  - src/xcom_tx.sv
  - src/xcom_rx.sv
  - src/xcom_top.sv
  - target: simulation
    files:
      - tb/tb_xcom_top.sv

// ==== build.f ====
src/xcom_pkg.sv
src/xcom_cmd.sv
src/req_ack_cmd.sv
src/xcom_loc_exec.sv
src/xcom_tx.sv
src/xcom_rx.sv
src/xcom_top.sv
tb/tb_xcom_top.sv
